// ==== Makefile ====
# Verilator simulation of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= project.f
BUILD_DIR ?= build
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --assert --timing

.PHONY: sim clean

# the log decides the result, not the exit code of the pipe
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/id_ifs.sv ====
//--------------------------------------
// decode bundle and register write port
//--------------------------------------
`timescale 1ns/1ps

// decoder output toward scoreboard and operand stage
interface dec_if import id_pkg::*; ();
    logic                  regs1_rd;
    logic [REG_ADDR_W-1:0] regs1_addr;
    logic                  regs2_rd;
    logic [REG_ADDR_W-1:0] regs2_addr;
    logic                  regd_tgt;
    logic [REG_ADDR_W-1:0] regd_addr;
    logic [XLEN-1:0]       imm;
    logic                  sels2_imm;
    alu_op_e               alu_op;
    logic [2:0]            funct3;
    zone_e                 zone;
    logic                  uerr;

    modport src  (output regs1_rd, regs1_addr, regs2_rd, regs2_addr, regd_tgt, regd_addr,
                  imm, sels2_imm, alu_op, funct3, zone, uerr);
    modport sb   (input regs1_rd, regs1_addr, regs2_rd, regs2_addr, regd_tgt, regd_addr,
                  zone);
    modport opnd (input regs1_rd, regs1_addr, regs2_rd, regs2_addr, regd_tgt, regd_addr,
                  imm, sels2_imm, alu_op, funct3, zone, uerr);
endinterface

// one register write port, execute write-back or lsq
interface wr_port_if import id_pkg::*; ();
    logic                  wr;
    logic [REG_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
    // load cancel, execute side only
    logic                  cncl_load;

    modport drv (output wr, addr, data, cncl_load);
    modport rf  (input wr, addr, data);
    modport sb  (input wr, addr, cncl_load);
    modport fwd (input wr, addr, data);
endinterface

// ==== hw/id_pkg.sv ====
//--------------------------------------
// decode stage widths, opcodes, enums
// and the instruction word union
//--------------------------------------
package id_pkg;

    // datapath and register file sizes
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // decoded major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // execute unit that takes the instruction
    typedef enum logic {
        ZONE_ALU   = 1'b0,
        ZONE_LOADQ = 1'b1
    } zone_e;

    // alu operation
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // one instruction word, r-type and i-type field views
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } rv_ins_u;

endpackage

// ==== hw/id_stage.sv ====
//--------------------------------------
// decode stage top, fetch ack and wiring
//--------------------------------------
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
    input  logic                  clk_i,
    input  logic                  resetb_i,
    // fetch
    input  logic                  pfu_dav_i,
    input  logic [31:0]           pfu_ins_i,
    output logic                  pfu_ack_o,
    // execute
    input  logic                  exs_stall_i,
    input  logic                  exs_regd_wr_i,
    input  logic [REG_ADDR_W-1:0] exs_regd_addr_i,
    input  logic [XLEN-1:0]       exs_regd_data_i,
    input  logic                  exs_regd_cncl_load_i,
    // load/store queue
    input  logic                  lsq_reg_wr_i,
    input  logic [REG_ADDR_W-1:0] lsq_reg_addr_i,
    input  logic [XLEN-1:0]       lsq_reg_data_i,
    // to execute
    output logic                  exs_valid_o,
    output logic                  exs_ins_uerr_o,
    output zone_e                 exs_zone_o,
    output alu_op_e               exs_alu_op_o,
    output logic [2:0]            exs_funct3_o,
    output logic [REG_ADDR_W-1:0] exs_regd_addr_o,
    output logic [XLEN-1:0]       exs_operand_left_o,
    output logic [XLEN-1:0]       exs_operand_right_o,
    output logic [XLEN-1:0]       exs_regs2_data_o
);

    rv_ins_u         ins_w;
    logic            sb_stall;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    dec_if     dec_bus ();
    wr_port_if exs_wb ();
    wr_port_if lsq_wb ();

    assign ins_w = pfu_ins_i;

    // write ports
    assign exs_wb.wr        = exs_regd_wr_i;
    assign exs_wb.addr      = exs_regd_addr_i;
    assign exs_wb.data      = exs_regd_data_i;
    assign exs_wb.cncl_load = exs_regd_cncl_load_i;
    assign lsq_wb.wr        = lsq_reg_wr_i;
    assign lsq_wb.addr      = lsq_reg_addr_i;
    assign lsq_wb.data      = lsq_reg_data_i;
    // lsq has no cancel
    assign lsq_wb.cncl_load = 1'b0;

    // take the fetch when no load hazard and execute has room
    assign pfu_ack_o = pfu_dav_i & ~sb_stall & (~exs_stall_i | ~exs_valid_o);

    ins_decoder u_decoder (
        .ins_i (ins_w),
        .dec   (dec_bus)
    );

    load_scoreboard u_scoreboard (
        .clk_i    (clk_i),
        .resetb_i (resetb_i),
        .dec      (dec_bus),
        .ack_i    (pfu_ack_o),
        .exs_wb   (exs_wb),
        .lsq_wb   (lsq_wb),
        .stall_o  (sb_stall)
    );

    regfile_integer u_regfile (
        .clk_i      (clk_i),
        .resetb_i   (resetb_i),
        .wa         (exs_wb),
        .wb         (lsq_wb),
        .rd_en_i    (pfu_ack_o),
        .rs1_addr_i (dec_bus.regs1_addr),
        .rs2_addr_i (dec_bus.regs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    operand_stage u_operand (
        .clk_i               (clk_i),
        .resetb_i            (resetb_i),
        .dec                 (dec_bus),
        .ack_i               (pfu_ack_o),
        .exs_stall_i         (exs_stall_i),
        .exs_wb              (exs_wb),
        .rs1_data_i          (rs1_data),
        .rs2_data_i          (rs2_data),
        .exs_valid_o         (exs_valid_o),
        .exs_ins_uerr_o      (exs_ins_uerr_o),
        .exs_zone_o          (exs_zone_o),
        .exs_alu_op_o        (exs_alu_op_o),
        .exs_funct3_o        (exs_funct3_o),
        .exs_regd_addr_o     (exs_regd_addr_o),
        .exs_operand_left_o  (exs_operand_left_o),
        .exs_operand_right_o (exs_operand_right_o),
        .exs_regs2_data_o    (exs_regs2_data_o)
    );

endmodule

// ==== hw/ins_decoder.sv ====
//--------------------------------------
// rv32i subset decoder
//--------------------------------------
`timescale 1ns/1ps

module ins_decoder import id_pkg::*; (
    input  rv_ins_u ins_i,
    dec_if.src      dec
);

    logic [31:0] ins_raw;
    logic        op_alt_ok;

    // funct3 to alu op, alt picks sub/sra
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign ins_raw = ins_i;

    // funct7 0100000 only legal for sub and sra
    assign op_alt_ok = (ins_i.r.funct7 == 7'b0100000) &&
                       (ins_i.r.funct3 == 3'b000 || ins_i.r.funct3 == 3'b101);

    always_comb begin
        // defaults from the r view
        dec.regs1_rd   = 1'b0;
        dec.regs1_addr = ins_i.r.rs1;
        dec.regs2_rd   = 1'b0;
        dec.regs2_addr = ins_i.r.rs2;
        dec.regd_tgt   = 1'b0;
        dec.regd_addr  = ins_i.r.rd;
        dec.imm        = {{(XLEN-12){ins_i.i.imm[11]}}, ins_i.i.imm};
        dec.sels2_imm  = 1'b0;
        dec.alu_op     = ALU_ADD;
        dec.funct3     = ins_i.r.funct3;
        dec.zone       = ZONE_ALU;
        dec.uerr       = 1'b0;
        case (ins_i.r.opcode)
            OPC_OP: begin
                dec.regs1_rd = 1'b1;
                dec.regs2_rd = 1'b1;
                dec.alu_op   = alu_from_funct3(ins_i.r.funct3, ins_i.r.funct7[5]);
                // reserved funct7 encodings
                if (ins_i.r.funct7 != 7'b0 && !op_alt_ok) begin
                    dec.uerr = 1'b1;
                end else begin
                    dec.regd_tgt = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                dec.regs1_rd  = 1'b1;
                dec.regd_tgt  = 1'b1;
                dec.sels2_imm = 1'b1;
                // srai is marked by bit 30, addi has no alternate
                dec.alu_op    = alu_from_funct3(ins_i.i.funct3,
                                    ins_i.i.funct3 == 3'b101 && ins_i.r.funct7[5]);
            end
            OPC_LOAD: begin
                dec.regs1_rd  = 1'b1;
                dec.regd_tgt  = 1'b1;
                dec.sels2_imm = 1'b1;
                dec.zone      = ZONE_LOADQ;
            end
            OPC_LUI: begin
                // x0 as left operand, upper immediate on the right
                dec.regs1_addr = '0;
                dec.regd_tgt   = 1'b1;
                dec.sels2_imm  = 1'b1;
                dec.imm        = {ins_raw[31:12], 12'h000};
            end
            default: begin
                dec.uerr = 1'b1;
            end
        endcase
    end

endmodule

// ==== hw/load_scoreboard.sv ====
//--------------------------------------
// pending load scoreboard and stall
//--------------------------------------
`timescale 1ns/1ps

module load_scoreboard import id_pkg::*; (
    input  logic  clk_i,
    input  logic  resetb_i,
    dec_if.sb     dec,
    input  logic  ack_i,
    wr_port_if.sb exs_wb,
    wr_port_if.sb lsq_wb,
    output logic  stall_o
);

    logic [NUM_REGS-1:1] pend_q;
    // full width view, x0 never pending
    logic [NUM_REGS-1:0] pend_vec;
    logic                load_set;
    logic                exs_clr;
    logic                lsq_clr;

    assign pend_vec = {pend_q, 1'b0};

    // acked load with a real destination
    assign load_set = ack_i && dec.zone == ZONE_LOADQ && dec.regd_tgt && dec.regd_addr != '0;
    assign exs_clr  = exs_wb.cncl_load && exs_wb.addr != '0;
    assign lsq_clr  = (lsq_wb.wr || lsq_wb.cncl_load) && lsq_wb.addr != '0;

    // hold off any source or target still waiting on a load
    assign stall_o = (dec.regs1_rd && pend_vec[dec.regs1_addr]) ||
                     (dec.regs2_rd && pend_vec[dec.regs2_addr]) ||
                     (dec.regd_tgt && pend_vec[dec.regd_addr]);

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            pend_q <= '0;
        end else begin
            if (load_set) begin
                pend_q[dec.regd_addr] <= 1'b1;
            end
            if (exs_clr) begin
                pend_q[exs_wb.addr] <= 1'b0;
            end
            if (lsq_clr) begin
                pend_q[lsq_wb.addr] <= 1'b0;
            end
        end
    end

    //--------------------------------------
    // checks
    //--------------------------------------
    // one outstanding load per register
    a_no_double_set: assert property (@(posedge clk_i) disable iff (!resetb_i)
        load_set |-> !pend_vec[dec.regd_addr]);
    // completions only for loads in flight
    a_lsq_clr_pend: assert property (@(posedge clk_i) disable iff (!resetb_i)
        lsq_clr |-> pend_vec[lsq_wb.addr]);
    a_exs_clr_pend: assert property (@(posedge clk_i) disable iff (!resetb_i)
        exs_clr |-> pend_vec[exs_wb.addr]);
    // top-level ack never lets a stale read through
    a_no_pend_read: assert property (@(posedge clk_i) disable iff (!resetb_i)
        ack_i |-> !(dec.regs1_rd && pend_vec[dec.regs1_addr]) &&
                  !(dec.regs2_rd && pend_vec[dec.regs2_addr]));

endmodule

// ==== hw/operand_stage.sv ====
//--------------------------------------
// execute hand-off, forwarding, operands
//--------------------------------------
`timescale 1ns/1ps

module operand_stage import id_pkg::*; (
    input  logic                  clk_i,
    input  logic                  resetb_i,
    dec_if.opnd                   dec,
    input  logic                  ack_i,
    input  logic                  exs_stall_i,
    wr_port_if.fwd                exs_wb,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    output logic                  exs_valid_o,
    output logic                  exs_ins_uerr_o,
    output zone_e                 exs_zone_o,
    output alu_op_e               exs_alu_op_o,
    output logic [2:0]            exs_funct3_o,
    output logic [REG_ADDR_W-1:0] exs_regd_addr_o,
    output logic [XLEN-1:0]       exs_operand_left_o,
    output logic [XLEN-1:0]       exs_operand_right_o,
    output logic [XLEN-1:0]       exs_regs2_data_o
);

    // forwarding register
    logic                  fwd_wr_q;
    logic [REG_ADDR_W-1:0] fwd_addr_q;
    logic [XLEN-1:0]       fwd_data_q;
    // held decode fields
    logic [XLEN-1:0]       imm_q;
    logic                  sels2_imm_q;
    logic [REG_ADDR_W-1:0] regs1_addr_q;
    logic [REG_ADDR_W-1:0] regs2_addr_q;
    // forwarded sources
    logic [XLEN-1:0]       fwd_rs1;
    logic [XLEN-1:0]       fwd_rs2;

    // newest copy of a source register
    function automatic logic [XLEN-1:0] fwd_pick(input logic [REG_ADDR_W-1:0] addr,
                                                 input logic [XLEN-1:0]       rf_data);
        logic [XLEN-1:0] res;
        if (addr == '0) begin
            res = rf_data;
        end else if (exs_wb.wr && exs_wb.addr == addr) begin
            // alu result this cycle
            res = exs_wb.data;
        end else if (fwd_wr_q && fwd_addr_q == addr) begin
            // write-back one cycle old, not yet in rf read data
            res = fwd_data_q;
        end else begin
            res = rf_data;
        end
        return res;
    endfunction

    //--------------------------------------
    // hand-off and forwarding registers
    //--------------------------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            exs_valid_o <= 1'b0;
            fwd_wr_q    <= 1'b0;
        end else begin
            if (!exs_stall_i) begin
                exs_valid_o <= ack_i;
            end
            fwd_wr_q <= exs_wb.wr;
        end
    end

    always_ff @(posedge clk_i) begin
        fwd_addr_q <= exs_wb.addr;
        fwd_data_q <= exs_wb.data;
    end

    // fields follow the accepted instruction
    always_ff @(posedge clk_i) begin
        if (ack_i) begin
            exs_ins_uerr_o  <= dec.uerr;
            exs_zone_o      <= dec.zone;
            exs_alu_op_o    <= dec.alu_op;
            exs_funct3_o    <= dec.funct3;
            exs_regd_addr_o <= dec.regd_tgt ? dec.regd_addr : '0;
            imm_q           <= dec.imm;
            sels2_imm_q     <= dec.sels2_imm;
            // source addr delay for the forwarding compare
            regs1_addr_q    <= dec.regs1_addr;
            regs2_addr_q    <= dec.regs2_addr;
        end
    end

    //--------------------------------------
    // forwarding and operand select
    //--------------------------------------
    always_comb begin
        fwd_rs1 = fwd_pick(regs1_addr_q, rs1_data_i);
        fwd_rs2 = fwd_pick(regs2_addr_q, rs2_data_i);
    end

    assign exs_operand_left_o  = fwd_rs1;
    assign exs_operand_right_o = sels2_imm_q ? imm_q : fwd_rs2;
    // store data path
    assign exs_regs2_data_o    = fwd_rs2;

endmodule

// ==== hw/regfile_integer.sv ====
//--------------------------------------
// integer register file, 2 wr / 2 rd
//--------------------------------------
`timescale 1ns/1ps

module regfile_integer import id_pkg::*; (
    input  logic                  clk_i,
    input  logic                  resetb_i,
    wr_port_if.rf                 wa,
    wr_port_if.rf                 wb,
    input  logic                  rd_en_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs_q [1:NUM_REGS-1];
    logic [XLEN-1:0] rs1_word;
    logic [XLEN-1:0] rs2_word;

    // both ports may land in the same cycle
    always_ff @(posedge clk_i) begin
        if (wa.wr && wa.addr != '0) begin
            regs_q[wa.addr] <= wa.data;
        end
        if (wb.wr && wb.addr != '0) begin
            regs_q[wb.addr] <= wb.data;
        end
    end

    // x0 reads as zero
    assign rs1_word = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_word = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

    // read data captured on ack
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            rs1_data_o <= '0;
            rs2_data_o <= '0;
        end else if (rd_en_i) begin
            rs1_data_o <= rs1_word;
            rs2_data_o <= rs2_word;
        end
    end

    // execute and lsq never race on one register
    a_no_wr_clash: assert property (@(posedge clk_i) disable iff (!resetb_i)
        !(wa.wr && wb.wr && wa.addr == wb.addr && wa.addr != '0));

endmodule

// ==== project.f ====
hw/id_pkg.sv
hw/id_ifs.sv
hw/ins_decoder.sv
hw/load_scoreboard.sv
hw/regfile_integer.sv
hw/operand_stage.sv
hw/id_stage.sv
verification/tb_id_stage.sv

// ==== verification/id_patterns.txt ====
# kind: 0 issue, 1 ex write, 2 lsq write, 3 ex cancel, 4 issue + stall (addr = cycles), 5 probe (data = ack)
# kind ins mode addr data left right uerr zone   (hex; mode 1 wb in ack cycle, 2 in valid cycle)
1 00000000 0 01 00000011 00000000 00000000 0 0
1 00000000 0 02 00000022 00000000 00000000 0 0
1 00000000 0 08 00000088 00000000 00000000 0 0
1 00000000 0 00 deadbeef 00000000 00000000 0 0
0 002081b3 0 00 00000000 00000011 00000022 0 0
0 40110233 0 00 00000000 00000022 00000011 0 0
0 001001b3 0 00 00000000 00000000 00000011 0 0
0 fff08293 0 00 00000000 00000011 ffffffff 0 0
0 7ff10313 0 00 00000000 00000022 000007ff 0 0
0 123453b7 0 00 00000000 00000000 12345000 0 0
0 002081b3 2 01 aaaa0001 aaaa0001 00000022 0 0
0 002081b3 1 02 bbbb0002 aaaa0001 bbbb0002 0 0
0 0080a283 0 00 00000000 aaaa0001 00000008 0 1
5 00228333 0 00 00000000 00000000 00000000 0 0
5 00100293 0 00 00000000 00000000 00000000 0 0
2 00000000 0 05 55667788 00000000 00000000 0 0
0 00228333 0 00 00000000 55667788 bbbb0002 0 0
0 00012403 0 00 00000000 bbbb0002 00000000 0 1
5 00040493 0 00 00000000 00000000 00000000 0 0
3 00000000 0 08 00000000 00000000 00000000 0 0
0 00040493 0 00 00000000 00000088 00000000 0 0
0 0000007f 0 00 00000000 00000000 00000000 1 0
0 022081b3 0 00 00000000 aaaa0001 bbbb0002 1 0
4 002081b3 0 03 00000000 aaaa0001 bbbb0002 0 0
0 0020c533 0 00 00000000 aaaa0001 bbbb0002 0 0

// ==== verification/tb_id_stage.sv ====
//--------------------------------------
// decode stage testbench, pattern driven
//--------------------------------------
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int MAX_PAT    = 64;
    localparam int ACK_WAIT   = 20;

    logic                  clk;
    logic                  resetb;
    logic                  pfu_dav;
    logic [31:0]           pfu_ins;
    logic                  pfu_ack;
    logic                  exs_stall;
    logic                  ex_wr;
    logic [REG_ADDR_W-1:0] ex_addr;
    logic [XLEN-1:0]       ex_data;
    logic                  ex_cncl;
    logic                  lsq_wr;
    logic [REG_ADDR_W-1:0] lsq_addr;
    logic [XLEN-1:0]       lsq_data;
    logic                  exs_valid;
    logic                  exs_uerr;
    zone_e                 exs_zone;
    alu_op_e               exs_alu_op;
    logic [2:0]            exs_funct3;
    logic [REG_ADDR_W-1:0] exs_regd_addr;
    logic [XLEN-1:0]       exs_left;
    logic [XLEN-1:0]       exs_right;
    logic [XLEN-1:0]       exs_regs2_data;

    // pattern table, one row per step
    logic [31:0] p_kind  [MAX_PAT];
    logic [31:0] p_ins   [MAX_PAT];
    logic [31:0] p_mode  [MAX_PAT];
    logic [31:0] p_addr  [MAX_PAT];
    logic [31:0] p_data  [MAX_PAT];
    logic [31:0] p_left  [MAX_PAT];
    logic [31:0] p_right [MAX_PAT];
    logic [31:0] p_uerr  [MAX_PAT];
    logic [31:0] p_zone  [MAX_PAT];
    int          pat_cnt = 0;

    id_stage u_dut (
        .clk_i                (clk),
        .resetb_i             (resetb),
        .pfu_dav_i            (pfu_dav),
        .pfu_ins_i            (pfu_ins),
        .pfu_ack_o            (pfu_ack),
        .exs_stall_i          (exs_stall),
        .exs_regd_wr_i        (ex_wr),
        .exs_regd_addr_i      (ex_addr),
        .exs_regd_data_i      (ex_data),
        .exs_regd_cncl_load_i (ex_cncl),
        .lsq_reg_wr_i         (lsq_wr),
        .lsq_reg_addr_i       (lsq_addr),
        .lsq_reg_data_i       (lsq_data),
        .exs_valid_o          (exs_valid),
        .exs_ins_uerr_o       (exs_uerr),
        .exs_zone_o           (exs_zone),
        .exs_alu_op_o         (exs_alu_op),
        .exs_funct3_o         (exs_funct3),
        .exs_regd_addr_o      (exs_regd_addr),
        .exs_operand_left_o   (exs_left),
        .exs_operand_right_o  (exs_right),
        .exs_regs2_data_o     (exs_regs2_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //--------------------------------------
    // reporting and compare helpers
    //--------------------------------------
    task automatic abort_run(input string what);
        $display("Error at %0t ns: %s", $time, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    // rv32i alu operation of a legal word
    function automatic alu_op_e expected_alu_op(input logic [31:0] ins);
        logic [31:0] by_funct3;
        logic [2:0]  f3;
        alu_op_e     op;
        by_funct3 = {ALU_AND, ALU_OR, ALU_SRL, ALU_XOR, ALU_SLTU, ALU_SLT, ALU_SLL, ALU_ADD};
        f3 = ins[14:12];
        op = alu_op_e'(by_funct3[f3*4 +: 4]);
        // loads and lui add, bit 30 picks sub on op and sra on shifts
        if (ins[6:0] == OPC_LOAD || ins[6:0] == OPC_LUI) begin
            op = ALU_ADD;
        end else if (ins[30] && f3 == 3'b101) begin
            op = ALU_SRA;
        end else if (ins[30] && f3 == 3'b000 && ins[6:0] == OPC_OP) begin
            op = ALU_SUB;
        end
        return op;
    endfunction

    // sampled at the falling edge, away from the drive edge
    task automatic check_outputs(input int idx);
        logic [31:0]           ins;
        logic [REG_ADDR_W-1:0] exp_rd;
        ins = p_ins[idx];
        // undefined words carry no destination
        exp_rd = (p_uerr[idx] != 32'd0) ? '0 : ins[11:7];
        compare_word("exs_valid_o", {31'b0, exs_valid}, 32'd1);
        compare_word("exs_operand_left_o", exs_left, p_left[idx]);
        compare_word("exs_operand_right_o", exs_right, p_right[idx]);
        compare_word("exs_ins_uerr_o", {31'b0, exs_uerr}, p_uerr[idx]);
        compare_word("exs_zone_o", {31'b0, exs_zone}, p_zone[idx]);
        compare_word("exs_funct3_o", {29'b0, exs_funct3}, {29'b0, ins[14:12]});
        compare_word("exs_regd_addr_o", {27'b0, exs_regd_addr}, {27'b0, exp_rd});
        if (p_uerr[idx] == 32'd0) begin
            compare_word("exs_alu_op_o", {28'b0, exs_alu_op},
                         {28'b0, expected_alu_op(ins)});
        end
        // second source value on register-register ops
        if (ins[6:0] == OPC_OP) begin
            compare_word("exs_regs2_data_o", exs_regs2_data, p_right[idx]);
        end
    endtask

    //--------------------------------------
    // step drivers
    //--------------------------------------
    // mode 1 writes back in the ack cycle, mode 2 in the valid cycle
    task automatic issue_step(input int idx, input logic hold);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk);
        pfu_dav <= 1'b1;
        pfu_ins <= p_ins[idx];
        if (p_mode[idx] == 32'd1) begin
            ex_wr   <= 1'b1;
            ex_addr <= p_addr[idx][REG_ADDR_W-1:0];
            ex_data <= p_data[idx];
        end
        @(negedge clk);
        while (!pfu_ack) begin
            wait_cnt++;
            if (wait_cnt > ACK_WAIT) begin
                abort_run("instruction was never accepted by the decode stage");
            end
            @(negedge clk);
        end
        @(posedge clk);
        ex_wr   <= 1'b0;
        pfu_dav <= hold;
        // execute back-pressure while the result is offered
        exs_stall <= hold;
        if (p_mode[idx] == 32'd2) begin
            ex_wr   <= 1'b1;
            ex_addr <= p_addr[idx][REG_ADDR_W-1:0];
            ex_data <= p_data[idx];
        end
        @(negedge clk);
        check_outputs(idx);
        if (hold) begin
            for (int c = 0; c < int'(p_addr[idx]); c++) begin
                compare_word("pfu_ack_o", {31'b0, pfu_ack}, 32'd0);
                @(negedge clk);
                check_outputs(idx);
            end
        end
        @(posedge clk);
        ex_wr     <= 1'b0;
        exs_stall <= 1'b0;
        pfu_dav   <= 1'b0;
    endtask

    // kind 1 write-back, 2 lsq write, 3 execute load cancel
    task automatic write_step(input int idx);
        @(posedge clk);
        case (p_kind[idx])
            32'd1: begin
                ex_wr   <= 1'b1;
                ex_addr <= p_addr[idx][REG_ADDR_W-1:0];
                ex_data <= p_data[idx];
            end
            32'd2: begin
                lsq_wr   <= 1'b1;
                lsq_addr <= p_addr[idx][REG_ADDR_W-1:0];
                lsq_data <= p_data[idx];
            end
            default: begin
                ex_cncl <= 1'b1;
                ex_addr <= p_addr[idx][REG_ADDR_W-1:0];
            end
        endcase
        @(posedge clk);
        ex_wr   <= 1'b0;
        lsq_wr  <= 1'b0;
        ex_cncl <= 1'b0;
    endtask

    // offer one instruction for a single cycle and check ack
    task automatic probe_step(input int idx);
        @(posedge clk);
        pfu_dav <= 1'b1;
        pfu_ins <= p_ins[idx];
        @(negedge clk);
        compare_word("pfu_ack_o", {31'b0, pfu_ack}, p_data[idx]);
        @(posedge clk);
        pfu_dav <= 1'b0;
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        int    cnt;
        string line;
        cnt = 0;
        fd = $fopen("verification/id_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("pattern file could not be opened");
        end
        while (!$feof(fd) && cnt < MAX_PAT) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", p_kind[cnt],
                            p_ins[cnt], p_mode[cnt], p_addr[cnt],
                            p_data[cnt], p_left[cnt], p_right[cnt],
                            p_uerr[cnt], p_zone[cnt]);
                if (n == 9) begin
                    cnt++;
                end
            end
        end
        $fclose(fd);
        // full count in one step, the watchdog waits on it
        pat_cnt = cnt;
    endtask

    //--------------------------------------
    // main sequence
    //--------------------------------------
    initial begin
        resetb    = 1'b0;
        pfu_dav   = 1'b0;
        pfu_ins   = '0;
        exs_stall = 1'b0;
        ex_wr     = 1'b0;
        ex_addr   = '0;
        ex_data   = '0;
        ex_cncl   = 1'b0;
        lsq_wr    = 1'b0;
        lsq_addr  = '0;
        lsq_data  = '0;
        load_patterns();
        if (pat_cnt == 0) begin
            abort_run("pattern file holds no steps");
        end
        repeat (16) @(posedge clk);
        resetb <= 1'b1;
        for (int i = 0; i < pat_cnt; i++) begin
            case (p_kind[i])
                32'd0:   issue_step(i, 1'b0);
                32'd4:   issue_step(i, 1'b1);
                32'd5:   probe_step(i);
                default: write_step(i);
            endcase
        end
        repeat (2) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

    // run length scales with the number of steps
    initial begin
        wait (pat_cnt > 0);
        #(pat_cnt * 40 * CLK_PERIOD);
        $display("Error: simulation timed out before all steps finished");
        $display("Regression failed");
        $fatal(1);
    end

endmodule
